// ==== Makefile ====
VERILATOR  ?= verilator
VFLAGS     = --binary --timing -j 0
LINT_FLAGS = --lint-only -Wall
TOP        = tb_wfilt_top
RTL_TOP    = wfilt_top
FILELIST   = compile.f
RTL_FILES  = wfilt_pkg.sv burst_if.sv aw_decode.sv burst_addr_gen.sv \
             wstrb_window_mask.sv wfilt_top.sv
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || (echo "simulation did not finish"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== aw_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module aw_decode
(
	input  wire logic               rvx_port_08,
	input  wire logic               rvx_port_04,
	input  wire logic               aw_valid,
	output logic                    aw_ready,
	input  wire wfilt_pkg::addr_t   aw_addr,
	input  wire wfilt_pkg::len_t    aw_len,
	input  wire wfilt_pkg::size_t   aw_size,
	input  wire wfilt_pkg::burst_e  aw_burst,
	input  wire logic               w_valid,
	output logic                    w_ready,
	output logic                    m_w_valid,
	input  wire logic               m_w_ready,
	burst_if.dec                    bus
);
	import wfilt_pkg::*;

	ctl_state_e state;
	logic       busy;
	logic       aw_fire;
	logic       w_fire;

	// Held copy of the accepted command
	addr_t      cmd_addr;
	len_t       cmd_len;
	size_t      cmd_size;
	burst_e     cmd_burst;

	// **************************************************
	// AW handshake
	// **************************************************

	assign busy     = (state == ST_BURST);
	// Only one burst in flight
	assign aw_ready = !busy;
	assign aw_fire  = aw_valid && aw_ready;

	always_ff @(posedge rvx_port_08 or negedge rvx_port_04)
	begin
		if (!rvx_port_04)
			state <= ST_IDLE;
		else if (aw_fire)
			state <= ST_BURST;
		// Leave on the accepted last beat
		else if (w_fire && bus.last)
			state <= ST_IDLE;
	end

	always_ff @(posedge rvx_port_08)
	begin
		if (aw_fire)
		begin
			cmd_addr  <= aw_addr;
			cmd_len   <= aw_len;
			cmd_size  <= aw_size;
			cmd_burst <= aw_burst;
		end
	end

	// Live AW fields at start, held copy for the rest of the burst
	assign bus.start = aw_fire;
	assign bus.addr  = busy ? cmd_addr  : aw_addr;
	assign bus.len   = busy ? cmd_len   : aw_len;
	assign bus.size  = busy ? cmd_size  : aw_size;
	assign bus.burst = busy ? cmd_burst : aw_burst;

	// **************************************************
	// W beat gating
	// **************************************************

	// Zero latency pass, closed while idle
	assign m_w_valid   = busy && w_valid;
	assign w_ready     = busy && m_w_ready;
	assign w_fire      = busy && w_valid && m_w_ready;
	assign bus.advance = w_fire;

endmodule

`default_nettype wire

// ==== burst_addr_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module burst_addr_gen
(
	input  wire logic  rvx_port_08,
	input  wire logic  rvx_port_04,
	burst_if.gen       bus
);
	import wfilt_pkg::*;

	// Address of the beat now on the W port
	addr_t cur_addr;
	// Beats left after the current one
	len_t  beat_cnt;

	addr_t size_bytes;
	addr_t size_mask;
	addr_t aligned_addr;
	addr_t incr_addr;
	addr_t wrap_bytes;
	addr_t wrap_mask;
	addr_t wrap_addr;
	addr_t next_addr;

	// **************************************************
	// Next beat address
	// **************************************************

	always_comb
	begin
		size_bytes   = addr_t'(1) << bus.size;
		size_mask    = size_bytes - addr_t'(1);
		// An unaligned start only shifts the first beat
		aligned_addr = cur_addr & ~size_mask;
		incr_addr    = aligned_addr + size_bytes;

		// Wrap block spans (len+1) beats of the transfer size
		wrap_bytes   = (addr_t'(bus.len) + addr_t'(1)) << bus.size;
		wrap_mask    = wrap_bytes - addr_t'(1);
		// Keep the block base, step only inside it
		wrap_addr    = (cur_addr & ~wrap_mask) | (incr_addr & wrap_mask);

		case (bus.burst)
			BURST_FIXED:
				next_addr = cur_addr;
			BURST_INCR:
				next_addr = incr_addr;
			BURST_WRAP:
				next_addr = wrap_addr;
			default:
				// Reserved type, hold the address
				next_addr = cur_addr;
		endcase
	end

	// **************************************************
	// Beat state
	// **************************************************

	always_ff @(posedge rvx_port_08)
	begin
		if (bus.start)
			cur_addr <= bus.addr;
		else if (bus.advance)
			cur_addr <= next_addr;
	end

	always_ff @(posedge rvx_port_08 or negedge rvx_port_04)
	begin
		if (!rvx_port_04)
			beat_cnt <= '0;
		else if (bus.start)
			beat_cnt <= bus.len;
		// Stop at zero, the FSM leaves the burst there
		else if (bus.advance && (beat_cnt != '0))
			beat_cnt <= beat_cnt - len_t'(1);
	end

	assign bus.beat_addr = cur_addr;
	assign bus.last      = (beat_cnt == '0);

endmodule

`default_nettype wire

// ==== burst_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface burst_if;
	import wfilt_pkg::*;

	// Command side, driven by the AW decoder
	logic     start;
	addr_t    addr;
	len_t     len;
	size_t    size;
	burst_e   burst;
	logic     advance;

	// Current beat, driven by the address generator
	addr_t    beat_addr;
	logic     last;

	// AW decoder drives the command and beat handshake
	modport dec (output start, output addr, output len, output size, output burst,
		output advance, input last);

	// Address generator follows the command
	modport gen (input start, input addr, input len, input size, input burst,
		input advance, output beat_addr, output last);

	// Strobe masker only needs the beat address
	modport mask (input start, input beat_addr);

endinterface

`default_nettype wire

// ==== compile.f ====
wfilt_pkg.sv
burst_if.sv
aw_decode.sv
burst_addr_gen.sv
wstrb_window_mask.sv
wfilt_top.sv
tb_wfilt_checker.sv
tb_wfilt_top.sv

// ==== tb_wfilt_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_wfilt_checker
(
	input  wire logic               rvx_port_08,
	input  wire logic               rvx_port_04,
	input  wire logic               aw_valid,
	input  wire logic               aw_ready,
	input  wire wfilt_pkg::addr_t   aw_addr,
	input  wire wfilt_pkg::len_t    aw_len,
	input  wire wfilt_pkg::size_t   aw_size,
	input  wire wfilt_pkg::burst_e  aw_burst,
	input  wire logic               w_valid,
	input  wire logic               w_ready,
	input  wire wfilt_pkg::data_t   w_data,
	input  wire wfilt_pkg::strb_t   w_strb,
	input  wire logic               m_w_valid,
	input  wire logic               m_w_ready,
	input  wire wfilt_pkg::data_t   m_w_data,
	input  wire wfilt_pkg::strb_t   m_w_strb,
	input  wire logic               m_w_last,
	input  wire wfilt_pkg::addr_t   win_lo,
	input  wire wfilt_pkg::addr_t   win_hi,
	input  wire logic               bypass,
	output int                      bursts_done,
	output int                      beats_done,
	output int                      error_count
);
	import wfilt_pkg::*;

	// Reference copy of the burst in flight
	logic   busy = 1'b0;
	addr_t  start_addr;
	len_t   len;
	size_t  size;
	burst_e kind;
	addr_t  lo;
	addr_t  hi;
	logic   pass_all;
	int     beat;
	int     burst_errors;
	string  name = "idle";
	addr_t  exp_addr;
	strb_t  exp_strb;
	logic   exp_last;

	// **************************************************
	// Reference rules
	// **************************************************

	// Byte address of beat n, AXI rules written with divide and modulo
	function automatic addr_t beat_address(addr_t start, len_t n_len, size_t n_size,
		burst_e n_kind, int n);
		addr_t step;
		addr_t aligned;
		addr_t span;
		addr_t base;
		step    = addr_t'(1) << n_size;
		aligned = (start / step) * step;
		// Wrap block is (len+1) transfers, aligned to its own size
		span    = step * (addr_t'(n_len) + addr_t'(1));
		base    = (start / span) * span;
		if (n == 0 || n_kind == BURST_FIXED)
			return start;
		else if (n_kind == BURST_WRAP)
			return base + (aligned - base + addr_t'(n) * step) % span;
		else
			return aligned + addr_t'(n) * step;
	endfunction

	// Lanes whose byte address falls in the inclusive window
	function automatic strb_t window_keep(addr_t addr, addr_t w_lo, addr_t w_hi);
		strb_t keep;
		addr_t byte_addr;
		for (int i = 0; i < STRB_W; i++)
		begin
			byte_addr = (addr & ~addr_t'(STRB_W - 1)) + addr_t'(i);
			keep[i]   = (byte_addr >= w_lo) && (byte_addr <= w_hi);
		end
		return keep;
	endfunction

	task automatic value_error(string what, logic [31:0] expected, logic [31:0] actual);
		$display("error %s %s: expected 0x%0h actual 0x%0h", name, what, expected, actual);
		burst_errors++;
		error_count++;
	endtask

	task automatic protocol_fault(string text);
		$display("%s: %s", name, text);
		burst_errors++;
		error_count++;
	endtask

	// **************************************************
	// Port watcher
	// **************************************************

	always @(posedge rvx_port_08 or negedge rvx_port_04)
	begin
		if (!rvx_port_04)
			busy = 1'b0;
		else if (!busy)
		begin
			if (!aw_ready)
				protocol_fault("aw_ready is low while no burst is open");
			if (m_w_valid || w_ready)
				protocol_fault("W path is open while no burst is open");
			if (aw_valid && aw_ready)
			begin
				// Command and window are taken on the AW accept edge
				start_addr   = aw_addr;
				len          = aw_len;
				size         = aw_size;
				kind         = aw_burst;
				lo           = win_lo;
				hi           = win_hi;
				pass_all     = bypass;
				beat         = 0;
				burst_errors = 0;
				busy         = 1'b1;
				bursts_done++;
				name = $sformatf("burst_%0d_%s%s", bursts_done, kind.name(),
					pass_all ? "_bypass" : "");
			end
		end
		else
		begin
			if (aw_ready)
				protocol_fault("aw_ready went high before the last beat");
			// Zero latency pass in both directions
			if (w_ready !== m_w_ready)
				value_error("w_ready", 32'(m_w_ready), 32'(w_ready));
			if (m_w_valid !== w_valid)
				value_error("m_w_valid", 32'(w_valid), 32'(m_w_valid));
			if (m_w_valid)
			begin
				exp_addr = beat_address(start_addr, len, size, kind, beat);
				exp_strb = pass_all ? w_strb : (w_strb & window_keep(exp_addr, lo, hi));
				exp_last = (beat == int'(len));
				if (m_w_strb !== exp_strb)
					value_error($sformatf("beat %0d strb", beat), 32'(exp_strb), 32'(m_w_strb));
				if (m_w_data !== w_data)
					value_error($sformatf("beat %0d data", beat), w_data, m_w_data);
				if (m_w_last !== exp_last)
					value_error($sformatf("beat %0d last", beat), 32'(exp_last), 32'(m_w_last));
			end
			if (m_w_valid && m_w_ready)
			begin
				beats_done++;
				beat++;
				// Burst closes after beat len+1
				if (beat > int'(len))
				begin
					$display("%s len %0d size %0d: %s", name, len, size,
						(burst_errors == 0) ? "ok" : "failed");
					busy = 1'b0;
					name = "idle";
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== tb_wfilt_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_wfilt_top;
	import wfilt_pkg::*;

	localparam int NUM_BURSTS = 80;
	// Cycles any single wait may take
	localparam int WAIT_LIMIT = 50;

	logic   rvx_port_08;
	logic   rvx_port_04;
	logic   aw_valid;
	logic   aw_ready;
	addr_t  aw_addr;
	len_t   aw_len;
	size_t  aw_size;
	burst_e aw_burst;
	logic   w_valid;
	logic   w_ready;
	data_t  w_data;
	strb_t  w_strb;
	logic   m_w_valid;
	logic   m_w_ready;
	data_t  m_w_data;
	strb_t  m_w_strb;
	logic   m_w_last;
	addr_t  win_lo;
	addr_t  win_hi;
	logic   bypass;

	int     bursts_done;
	int     beats_done;
	int     error_count;
	int     beats_sent;
	logic   hung;

	wfilt_top dut
	(
		.rvx_port_08 (rvx_port_08),
		.rvx_port_04 (rvx_port_04),
		.aw_valid    (aw_valid),
		.aw_ready    (aw_ready),
		.aw_addr     (aw_addr),
		.aw_len      (aw_len),
		.aw_size     (aw_size),
		.aw_burst    (aw_burst),
		.w_valid     (w_valid),
		.w_ready     (w_ready),
		.w_data      (w_data),
		.w_strb      (w_strb),
		.m_w_valid   (m_w_valid),
		.m_w_ready   (m_w_ready),
		.m_w_data    (m_w_data),
		.m_w_strb    (m_w_strb),
		.m_w_last    (m_w_last),
		.win_lo      (win_lo),
		.win_hi      (win_hi),
		.bypass      (bypass)
	);

	tb_wfilt_checker u_checker
	(
		.rvx_port_08 (rvx_port_08),
		.rvx_port_04 (rvx_port_04),
		.aw_valid    (aw_valid),
		.aw_ready    (aw_ready),
		.aw_addr     (aw_addr),
		.aw_len      (aw_len),
		.aw_size     (aw_size),
		.aw_burst    (aw_burst),
		.w_valid     (w_valid),
		.w_ready     (w_ready),
		.w_data      (w_data),
		.w_strb      (w_strb),
		.m_w_valid   (m_w_valid),
		.m_w_ready   (m_w_ready),
		.m_w_data    (m_w_data),
		.m_w_strb    (m_w_strb),
		.m_w_last    (m_w_last),
		.win_lo      (win_lo),
		.win_hi      (win_hi),
		.bypass      (bypass),
		.bursts_done (bursts_done),
		.beats_done  (beats_done),
		.error_count (error_count)
	);

	// 100 ns clock
	initial
	begin
		rvx_port_08 = 1'b0;
		forever
			#50 rvx_port_08 = ~rvx_port_08;
	end

	// **************************************************
	// Stimulus tasks
	// **************************************************

	// Random legal AW command plus a window near its start
	task automatic drive_command();
		logic [1:0] wrap_pick;
		aw_burst = burst_e'($urandom_range(0, 2));
		aw_size  = size_t'($urandom_range(0, 2));
		aw_addr  = $urandom;
		if (aw_burst == BURST_WRAP)
		begin
			// Wrap takes 2, 4 or 8 beats and an aligned start
			wrap_pick = 2'($urandom_range(1, 3));
			aw_len    = len_t'((1 << wrap_pick) - 1);
			aw_addr   = aw_addr & ~((addr_t'(1) << aw_size) - addr_t'(1));
		end
		else
			aw_len = len_t'($urandom_range(0, 7));
		// Window may start before, inside or past the burst, and may be empty
		win_lo   = aw_addr + $urandom_range(0, 24) - 32'd12;
		win_hi   = win_lo + $urandom_range(0, 40) - 32'd4;
		bypass   = ($urandom_range(0, 4) == 0);
		aw_valid = 1'b1;
	endtask

	task automatic wait_aw_accept();
		int   cycles;
		logic done;
		cycles = 0;
		done   = 1'b0;
		while (!done && !hung)
		begin
			@(posedge rvx_port_08);
			done = aw_valid && aw_ready;
			cycles++;
			if (!done && cycles >= WAIT_LIMIT)
			begin
				$display("timeout: AW command was never accepted");
				hung = 1'b1;
			end
		end
		@(negedge rvx_port_08);
		aw_valid = 1'b0;
		// Scramble the AW fields and window so only held copies are valid
		aw_addr  = $urandom;
		aw_len   = len_t'($urandom_range(0, 7));
		aw_size  = size_t'($urandom_range(0, 2));
		aw_burst = burst_e'($urandom_range(0, 2));
		win_lo   = $urandom;
		win_hi   = $urandom;
		bypass   = ($urandom_range(0, 1) != 0);
	endtask

	// Random gaps upstream and stalls downstream
	task automatic send_beats(int n_beats);
		int   sent;
		int   stalled;
		logic fired;
		sent    = 0;
		stalled = 0;
		while (sent < n_beats && !hung)
		begin
			// Data holds while valid is up
			if (!w_valid && ($urandom_range(0, 3) != 0))
			begin
				w_valid = 1'b1;
				w_data  = $urandom;
				w_strb  = strb_t'($urandom_range(0, 15));
			end
			m_w_ready = ($urandom_range(0, 2) != 0);
			@(posedge rvx_port_08);
			fired = w_valid && w_ready;
			@(negedge rvx_port_08);
			if (fired)
			begin
				sent++;
				stalled = 0;
				w_valid = 1'b0;
			end
			else
			begin
				stalled++;
				if (stalled >= WAIT_LIMIT)
				begin
					$display("timeout: W beat %0d was never accepted", sent);
					hung = 1'b1;
				end
			end
		end
		beats_sent += sent;
		// Traffic waits on the idle W path until the next burst opens
		m_w_ready = ($urandom_range(0, 1) != 0);
		if (!w_valid && ($urandom_range(0, 1) != 0))
		begin
			w_valid = 1'b1;
			w_data  = $urandom;
			w_strb  = strb_t'($urandom_range(0, 15));
		end
	endtask

	// **************************************************
	// Main sequence
	// **************************************************

	initial
	begin
		len_t cur_len;
		void'($urandom(61119));
		hung        = 1'b0;
		beats_sent  = 0;
		rvx_port_04 = 1'b0;
		aw_valid    = 1'b0;
		aw_addr     = '0;
		aw_len      = '0;
		aw_size     = '0;
		aw_burst    = BURST_INCR;
		w_valid     = 1'b0;
		w_data      = '0;
		w_strb      = '0;
		m_w_ready   = 1'b0;
		win_lo      = '0;
		win_hi      = '0;
		bypass      = 1'b0;
		repeat (3) @(posedge rvx_port_08);
		@(negedge rvx_port_08);
		rvx_port_04 = 1'b1;

		for (int n = 0; n < NUM_BURSTS && !hung; n++)
		begin
			repeat ($urandom_range(0, 2)) @(negedge rvx_port_08);
			drive_command();
			cur_len = aw_len;
			wait_aw_accept();
			send_beats(int'(cur_len) + 1);
		end
		repeat (2) @(negedge rvx_port_08);

		$display("bursts %0d beats %0d errors %0d", bursts_done, beats_done, error_count);
		if (beats_sent != beats_done)
			$display("beats sent upstream (%0d) differ from beats seen downstream (%0d)",
				beats_sent, beats_done);
		if (hung || error_count != 0 || beats_sent != beats_done)
			$display("RESULT: FAIL");
		else
			$display("RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== wfilt_pkg.sv ====
`default_nettype none

package wfilt_pkg;

	// **************************************************
	// Bus widths
	// **************************************************

	// Address and window bound width
	localparam int ADDR_W = 32;
	// W data bus width
	localparam int DATA_W = 32;
	// One strobe bit per byte lane
	localparam int STRB_W = DATA_W / 8;
	// Address bits that pick a byte lane
	localparam int LANE_W = 2;

	// **************************************************
	// Vector types
	// **************************************************

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] data_t;
	typedef logic [STRB_W-1:0] strb_t;
	// Beats minus one, as on AXI AWLEN
	typedef logic [7:0]        len_t;
	// log2 of bytes per beat, as on AXI AWSIZE
	typedef logic [2:0]        size_t;

	// AXI burst type encoding
	typedef enum logic [1:0]
	{
		BURST_FIXED = 2'd0,
		BURST_INCR  = 2'd1,
		BURST_WRAP  = 2'd2
	} burst_e;

	// Control FSM in aw_decode
	typedef enum logic
	{
		ST_IDLE  = 1'b0,
		ST_BURST = 1'b1
	} ctl_state_e;

endpackage

`default_nettype wire

// ==== wfilt_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module wfilt_top
(
	input  wire logic               rvx_port_08,
	input  wire logic               rvx_port_04,

	// AW channel
	input  wire logic               aw_valid,
	output logic                    aw_ready,
	input  wire wfilt_pkg::addr_t   aw_addr,
	input  wire wfilt_pkg::len_t    aw_len,
	input  wire wfilt_pkg::size_t   aw_size,
	input  wire wfilt_pkg::burst_e  aw_burst,

	// Upstream W channel
	input  wire logic               w_valid,
	output logic                    w_ready,
	input  wire wfilt_pkg::data_t   w_data,
	input  wire wfilt_pkg::strb_t   w_strb,

	// Downstream W channel
	output logic                    m_w_valid,
	input  wire logic               m_w_ready,
	output wfilt_pkg::data_t        m_w_data,
	output wfilt_pkg::strb_t        m_w_strb,
	output logic                    m_w_last,

	// Byte window, taken at AW accept
	input  wire wfilt_pkg::addr_t   win_lo,
	input  wire wfilt_pkg::addr_t   win_hi,
	input  wire logic               bypass
);

	// **************************************************
	// Burst command and beat address between blocks
	// **************************************************

	burst_if u_bus ();

	aw_decode u_aw_decode
	(
		.rvx_port_08 (rvx_port_08),
		.rvx_port_04 (rvx_port_04),
		.aw_valid    (aw_valid),
		.aw_ready    (aw_ready),
		.aw_addr     (aw_addr),
		.aw_len      (aw_len),
		.aw_size     (aw_size),
		.aw_burst    (aw_burst),
		.w_valid     (w_valid),
		.w_ready     (w_ready),
		.m_w_valid   (m_w_valid),
		.m_w_ready   (m_w_ready),
		.bus         (u_bus)
	);

	burst_addr_gen u_addr_gen
	(
		.rvx_port_08 (rvx_port_08),
		.rvx_port_04 (rvx_port_04),
		.bus         (u_bus)
	);

	wstrb_window_mask u_mask
	(
		.rvx_port_08 (rvx_port_08),
		.rvx_port_04 (rvx_port_04),
		.win_lo      (win_lo),
		.win_hi      (win_hi),
		.bypass      (bypass),
		.w_strb      (w_strb),
		.m_w_strb    (m_w_strb),
		.bus         (u_bus)
	);

	// Data is never touched
	assign m_w_data = w_data;
	// Last beat comes from the beat counter, not from upstream
	assign m_w_last = u_bus.last;

endmodule

`default_nettype wire

// ==== wstrb_window_mask.sv ====
`timescale 1ns/10ps
`default_nettype none

module wstrb_window_mask
(
	input  wire logic              rvx_port_08,
	input  wire logic              rvx_port_04,
	input  wire wfilt_pkg::addr_t  win_lo,
	input  wire wfilt_pkg::addr_t  win_hi,
	input  wire logic              bypass,
	input  wire wfilt_pkg::strb_t  w_strb,
	output wfilt_pkg::strb_t       m_w_strb,
	burst_if.mask                  bus
);
	import wfilt_pkg::*;

	// Window bounds for the burst in flight
	addr_t win_lo_q;
	addr_t win_hi_q;
	// Bypass for the burst in flight
	logic  bypass_q;

	// Word part and lane part of each address
	logic [ADDR_W-LANE_W-1:0] lo_word;
	logic [ADDR_W-LANE_W-1:0] hi_word;
	logic [ADDR_W-LANE_W-1:0] beat_word;
	logic [LANE_W-1:0]        lo_lane;
	logic [LANE_W-1:0]        hi_lane;

	// Lanes kept when the beat shares a word with a bound
	strb_t lo_edge;
	strb_t hi_edge;
	strb_t keep_lo;
	strb_t keep_hi;

	always_ff @(posedge rvx_port_08 or negedge rvx_port_04)
	begin
		if (!rvx_port_04)
		begin
			win_lo_q <= '0;
			win_hi_q <= '0;
			bypass_q <= 1'b0;
		end
		else if (bus.start)
		begin
			win_lo_q <= win_lo;
			win_hi_q <= win_hi;
			bypass_q <= bypass;
		end
	end

	assign {lo_word, lo_lane} = win_lo_q;
	assign {hi_word, hi_lane} = win_hi_q;
	assign beat_word          = bus.beat_addr[ADDR_W-1:LANE_W];

	// **************************************************
	// Per lane keep bits
	// **************************************************

	always_comb
	begin
		for (int i = 0; i < STRB_W; i++)
		begin
			lo_edge[i] = (lo_lane <= LANE_W'(i));
			hi_edge[i] = (hi_lane >= LANE_W'(i));
		end

		// Lower bound keeps a partial word only when the words match
		if (beat_word == lo_word)
			keep_lo = lo_edge;
		else if (beat_word < lo_word)
			keep_lo = '0;
		else
			keep_lo = '1;

		// Upper bound mirrors the lower one
		if (beat_word == hi_word)
			keep_hi = hi_edge;
		else if (beat_word > hi_word)
			keep_hi = '0;
		else
			keep_hi = '1;

		if (bypass_q)
			m_w_strb = w_strb;
		else
			m_w_strb = w_strb & keep_lo & keep_hi;
	end

endmodule

`default_nettype wire
